//--- valu_pkg.sv
package valu_pkg;

    localparam int DATA_W   = 64;
    localparam int BE_W     = DATA_W / 8;
    localparam int FUNC_W   = 6;
    localparam int RESP_LAT = 3;   // decode + unit + collect

    typedef enum logic [1:0] {
        SEW8  = 2'd0,
        SEW16 = 2'd1,
        SEW32 = 2'd2,
        SEW64 = 2'd3
    } sew_e;

    // op_mnr codes of the vector-integer formats
    localparam logic [2:0] OPIVV = 3'd0;
    localparam logic [2:0] OPIVI = 3'd3;
    localparam logic [2:0] OPIVX = 3'd4;

    typedef struct packed {
        logic [3:0] grp;   // 0010 = logical ops
        logic [1:0] sel;   // and / or / xor
    } func_grp_t;

    typedef struct packed {
        logic [2:0] cls;   // 000 = add/sub/min/max
        logic [2:0] sub;
    } func_cls_t;

    typedef union packed {
        func_grp_t g;
        func_cls_t c;
    } func_id_u;

    localparam logic [FUNC_W-1:0] F_MERGE = 6'b010111;   // vmerge / vmv.v

    typedef enum logic [2:0] {
        AND,
        OR,
        XOR,
        MOVE,
        MERGE
    } bit_op_e;

    typedef enum logic [2:0] {
        ADD,
        SUB,
        RSUB,
        MINU,
        MIN,
        MAXU,
        MAX
    } add_op_e;

    typedef struct packed {
        sew_e            sew;
        logic [BE_W-1:0] be;
        logic            first;
        logic            last;
    } side_t;

    typedef struct packed {
        logic    bit_en;
        logic    add_en;
        bit_op_e bit_op;
        add_op_e add_op;
        sew_e    sew;
    } issue_t;

    typedef struct packed {
        logic              valid;
        logic [DATA_W-1:0] data;
    } unit_out_t;

endpackage

//--- valu_decode.sv
module valu_decode #(
    parameter int ADDR_WIDTH = 32
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          req_valid,
    input  logic [2:0]                    req_op_mnr,
    input  logic [valu_pkg::FUNC_W-1:0]   req_func_id,
    input  valu_pkg::sew_e                req_sew,
    input  logic [valu_pkg::DATA_W-1:0]   req_data0,
    input  logic [valu_pkg::DATA_W-1:0]   req_data1,
    input  logic [ADDR_WIDTH-1:0]         req_addr,
    input  logic [valu_pkg::BE_W-1:0]     req_be,
    input  logic                          req_start,
    input  logic                          req_end,
    input  logic                          req_mask,
    output valu_pkg::issue_t              issue,
    output logic [valu_pkg::DATA_W-1:0]   op0,
    output logic [valu_pkg::DATA_W-1:0]   op1,
    output valu_pkg::side_t               side0,
    output logic [ADDR_WIDTH-1:0]         addr0
);
    import valu_pkg::*;

    func_id_u fid;
    logic     is_int;
    logic     bit_hit;
    logic     add_hit;
    bit_op_e  bit_op_n;
    add_op_e  add_op_n;

    assign fid    = req_func_id;
    assign is_int = (req_op_mnr == OPIVV) || (req_op_mnr == OPIVI) || (req_op_mnr == OPIVX);

    always_comb begin
        bit_hit  = 1'b0;
        add_hit  = 1'b0;
        bit_op_n = AND;
        add_op_n = ADD;
        if (req_valid && is_int) begin
            if (req_func_id == F_MERGE) begin
                bit_hit = 1'b1;
                if (req_mask) begin
                    bit_op_n = MOVE;   // vmv.v, unmasked form
                end else begin
                    bit_op_n = MERGE;
                end
            end else if (fid.g.grp == 4'b0010 && fid.g.sel != 2'b00) begin
                bit_hit = 1'b1;
                case (fid.g.sel)
                    2'b01:   bit_op_n = AND;
                    2'b10:   bit_op_n = OR;
                    default: bit_op_n = XOR;
                endcase
            end else if (fid.c.cls == 3'b000) begin
                add_hit = 1'b1;
                case (fid.c.sub)
                    3'd0:    add_op_n = ADD;
                    3'd2:    add_op_n = SUB;
                    3'd3:    add_op_n = RSUB;
                    3'd4:    add_op_n = MINU;
                    3'd5:    add_op_n = MIN;
                    3'd6:    add_op_n = MAXU;
                    3'd7:    add_op_n = MAX;
                    default: add_hit  = 1'b0;   // sub 1 is reserved
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            issue <= '0;
            side0 <= '0;
            addr0 <= '0;
        end else begin
            issue.bit_en <= bit_hit;
            issue.add_en <= add_hit;
            issue.bit_op <= bit_op_n;
            issue.add_op <= add_op_n;
            issue.sew    <= req_sew;
            if (bit_hit || add_hit) begin
                side0.sew   <= req_sew;
                side0.be    <= req_be;
                side0.first <= req_start;
                side0.last  <= req_end;
                addr0       <= req_addr;
            end else begin
                side0 <= '0;   // no response, so no sideband either
                addr0 <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        op0 <= req_data0;
        op1 <= req_data1;
    end

endmodule

//--- valu_bitwise_unit.sv
module valu_bitwise_unit (
    input  logic                          clk,
    input  logic                          rst,
    input  valu_pkg::issue_t              issue,
    input  logic [valu_pkg::DATA_W-1:0]   op0,
    input  logic [valu_pkg::DATA_W-1:0]   op1,
    input  logic [valu_pkg::BE_W-1:0]     be,
    output valu_pkg::unit_out_t           res
);
    import valu_pkg::*;

    logic [DATA_W-1:0] merged;
    logic [DATA_W-1:0] result;

    // byte-wise select for vmerge
    always_comb begin
        for (int b = 0; b < BE_W; b++) begin
            merged[b*8 +: 8] = be[b] ? op0[b*8 +: 8] : op1[b*8 +: 8];
        end
    end

    always_comb begin
        case (issue.bit_op)
            AND:     result = op1 & op0;
            OR:      result = op1 | op0;
            XOR:     result = op1 ^ op0;
            MOVE:    result = op0;   // vs1 / scalar / imm straight through
            MERGE:   result = merged;
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            res <= '0;
        end else begin
            res.valid <= issue.bit_en;
            res.data  <= issue.bit_en ? result : '0;   // zero so collect can OR
        end
    end

endmodule

//--- valu_add_unit.sv
module valu_add_unit (
    input  logic                          clk,
    input  logic                          rst,
    input  valu_pkg::issue_t              issue,
    input  logic [valu_pkg::DATA_W-1:0]   op0,
    input  logic [valu_pkg::DATA_W-1:0]   op1,
    output valu_pkg::unit_out_t           res
);
    import valu_pkg::*;

    logic [3:0][DATA_W-1:0] lane;   // one full result word per sew

    for (genvar s = 0; s < 4; s++) begin : g_sew
        localparam int EW = 8 << s;

        for (genvar e = 0; e < DATA_W / EW; e++) begin : g_elem
            logic [EW-1:0] a;
            logic [EW-1:0] b;
            logic [EW-1:0] y;
            logic          lt_u;
            logic          lt_s;

            assign a    = op1[e*EW +: EW];   // vs2
            assign b    = op0[e*EW +: EW];   // vs1
            assign lt_u = a < b;
            assign lt_s = $signed(a) < $signed(b);

            // carries stay inside the element, sums wrap at EW bits
            always_comb begin
                case (issue.add_op)
                    ADD:     y = a + b;
                    SUB:     y = a - b;
                    RSUB:    y = b - a;
                    MINU:    y = lt_u ? a : b;
                    MIN:     y = lt_s ? a : b;
                    MAXU:    y = lt_u ? b : a;
                    MAX:     y = lt_s ? b : a;
                    default: y = '0;
                endcase
            end

            assign lane[s][e*EW +: EW] = y;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            res <= '0;
        end else begin
            res.valid <= issue.add_en;
            res.data  <= issue.add_en ? lane[issue.sew] : '0;
        end
    end

endmodule

//--- valu_collect.sv
module valu_collect #(
    parameter int ADDR_WIDTH = 32
) (
    input  logic                          clk,
    input  logic                          rst,
    input  valu_pkg::unit_out_t           bit_res,
    input  valu_pkg::unit_out_t           add_res,
    input  valu_pkg::side_t               side0,
    input  logic [ADDR_WIDTH-1:0]         addr0,
    output logic                          resp_valid,
    output logic [valu_pkg::DATA_W-1:0]   resp_data,
    output logic [ADDR_WIDTH-1:0]         resp_addr,
    output logic [valu_pkg::BE_W-1:0]     resp_be,
    output valu_pkg::sew_e                resp_sew,
    output logic                          resp_start,
    output logic                          resp_end
);
    import valu_pkg::*;

    side_t                 side1;   // lines up with the unit stage
    logic [ADDR_WIDTH-1:0] addr1;

    always_ff @(posedge clk) begin
        if (rst) begin
            side1 <= '0;
            addr1 <= '0;
        end else begin
            side1 <= side0;
            addr1 <= addr0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            resp_valid <= 1'b0;
            resp_data  <= '0;
            resp_addr  <= '0;
            resp_be    <= '0;
            resp_sew   <= SEW8;
            resp_start <= 1'b0;
            resp_end   <= 1'b0;
        end else begin
            // at most one unit is active, the other one drives zeros
            resp_valid <= bit_res.valid | add_res.valid;
            resp_data  <= bit_res.data | add_res.data;
            resp_addr  <= addr1;
            resp_be    <= side1.be;
            resp_sew   <= side1.sew;
            resp_start <= side1.first;
            resp_end   <= side1.last;
        end
    end

endmodule

//--- valu_top.sv
module valu_top #(
    parameter int ADDR_WIDTH = 32
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          req_valid,
    input  logic [2:0]                    req_op_mnr,
    input  logic [valu_pkg::FUNC_W-1:0]   req_func_id,
    input  valu_pkg::sew_e                req_sew,
    input  logic [valu_pkg::DATA_W-1:0]   req_data0,
    input  logic [valu_pkg::DATA_W-1:0]   req_data1,
    input  logic [ADDR_WIDTH-1:0]         req_addr,
    input  logic [valu_pkg::BE_W-1:0]     req_be,
    input  logic                          req_start,
    input  logic                          req_end,
    input  logic                          req_mask,
    output logic                          resp_valid,
    output logic [valu_pkg::DATA_W-1:0]   resp_data,
    output logic [ADDR_WIDTH-1:0]         resp_addr,
    output logic [valu_pkg::BE_W-1:0]     resp_be,
    output valu_pkg::sew_e                resp_sew,
    output logic                          resp_start,
    output logic                          resp_end
);
    import valu_pkg::*;

    issue_t                issue;
    logic [DATA_W-1:0]     op0;
    logic [DATA_W-1:0]     op1;
    side_t                 side0;
    logic [ADDR_WIDTH-1:0] addr0;
    unit_out_t             bit_res;
    unit_out_t             add_res;

    valu_decode #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_decode (
        .clk         (clk),
        .rst         (rst),
        .req_valid   (req_valid),
        .req_op_mnr  (req_op_mnr),
        .req_func_id (req_func_id),
        .req_sew     (req_sew),
        .req_data0   (req_data0),
        .req_data1   (req_data1),
        .req_addr    (req_addr),
        .req_be      (req_be),
        .req_start   (req_start),
        .req_end     (req_end),
        .req_mask    (req_mask),
        .issue       (issue),
        .op0         (op0),
        .op1         (op1),
        .side0       (side0),
        .addr0       (addr0)
    );

    valu_bitwise_unit u_bitwise (
        .clk   (clk),
        .rst   (rst),
        .issue (issue),
        .op0   (op0),
        .op1   (op1),
        .be    (side0.be),   // merge mask
        .res   (bit_res)
    );

    valu_add_unit u_add (
        .clk   (clk),
        .rst   (rst),
        .issue (issue),
        .op0   (op0),
        .op1   (op1),
        .res   (add_res)
    );

    valu_collect #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_collect (
        .clk        (clk),
        .rst        (rst),
        .bit_res    (bit_res),
        .add_res    (add_res),
        .side0      (side0),
        .addr0      (addr0),
        .resp_valid (resp_valid),
        .resp_data  (resp_data),
        .resp_addr  (resp_addr),
        .resp_be    (resp_be),
        .resp_sew   (resp_sew),
        .resp_start (resp_start),
        .resp_end   (resp_end)
    );

endmodule

//--- valu_tb_sva.sv
module valu_tb_sva (
    input logic                        clk,
    input logic                        rst,
    input logic                        resp_valid,
    input logic [valu_pkg::DATA_W-1:0] resp_data,
    input logic                        resp_start,
    input logic                        resp_end
);

    a_start_valid: assert property (@(posedge clk) disable iff (rst) resp_start |-> resp_valid)
        else $error("resp_start high without resp_valid");

    a_end_valid: assert property (@(posedge clk) disable iff (rst) resp_end |-> resp_valid)
        else $error("resp_end high without resp_valid");

    // result word must be fully known when it is delivered
    a_data_known: assert property (@(posedge clk) disable iff (rst)
        resp_valid |-> !$isunknown(resp_data))
        else $error("resp_data has X or Z bits while resp_valid is high");

    a_reset_idle: assert property (@(posedge clk) rst |=> !resp_valid)
        else $error("resp_valid high in the cycle after reset");

endmodule

bind valu_top valu_tb_sva u_sva (
    .clk        (clk),
    .rst        (rst),
    .resp_valid (resp_valid),
    .resp_data  (resp_data),
    .resp_start (resp_start),
    .resp_end   (resp_end)
);

//--- valu_tb.sv
module valu_tb;
    import valu_pkg::*;

    localparam int ADDR_W   = 32;
    localparam int N_BIT    = 60;
    localparam int N_MERGE  = 40;
    localparam int N_ADD    = 80;
    localparam int N_MINMAX = 80;
    localparam int N_MIX    = 120;   // slots with some idle ones among them
    localparam int TOTAL    = N_BIT + N_MERGE + N_ADD + N_MINMAX + N_MIX;

    typedef struct packed {
        logic [31:0]       stamp;   // cycle in which the request is on the inputs
        logic [DATA_W-1:0] data;
        logic [ADDR_W-1:0] addr;
        logic [BE_W-1:0]   be;
        logic [1:0]        sew;
        logic              first;
        logic              last;
    } exp_t;

    logic              clk = 1'b0;
    logic              rst;
    logic              req_valid;
    logic [2:0]        req_op_mnr;
    logic [FUNC_W-1:0] req_func_id;
    sew_e              req_sew;
    logic [DATA_W-1:0] req_data0;
    logic [DATA_W-1:0] req_data1;
    logic [ADDR_W-1:0] req_addr;
    logic [BE_W-1:0]   req_be;
    logic              req_start;
    logic              req_end;
    logic              req_mask;
    logic              resp_valid;
    logic [DATA_W-1:0] resp_data;
    logic [ADDR_W-1:0] resp_addr;
    logic [BE_W-1:0]   resp_be;
    sew_e              resp_sew;
    logic              resp_start;
    logic              resp_end;

    exp_t        exp_q[$];
    logic [63:0] rng = 64'd6;
    int          cyc = 0;
    int          errors = 0;
    int          last_errors = 0;
    logic        started = 1'b0;

    valu_top #(
        .ADDR_WIDTH (ADDR_W)
    ) UUT (
        .clk         (clk),
        .rst         (rst),
        .req_valid   (req_valid),
        .req_op_mnr  (req_op_mnr),
        .req_func_id (req_func_id),
        .req_sew     (req_sew),
        .req_data0   (req_data0),
        .req_data1   (req_data1),
        .req_addr    (req_addr),
        .req_be      (req_be),
        .req_start   (req_start),
        .req_end     (req_end),
        .req_mask    (req_mask),
        .resp_valid  (resp_valid),
        .resp_data   (resp_data),
        .resp_addr   (resp_addr),
        .resp_be     (resp_be),
        .resp_sew    (resp_sew),
        .resp_start  (resp_start),
        .resp_end    (resp_end)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    function automatic logic [63:0] xorshift(input logic [63:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 7);
        x = x ^ (x << 17);
        return x;
    endfunction

    task automatic next_rand(output logic [63:0] r);
        rng = xorshift(rng);
        r = rng;
    endtask

    // elements around the signed and unsigned wrap points
    function automatic logic [63:0] edge_word(input logic [1:0] sew, input logic [63:0] r);
        logic [63:0] w;
        logic [63:0] m;
        logic [63:0] v;
        int          ew;
        ew = 8 << sew;
        m  = (ew == 64) ? {64{1'b1}} : ((64'd1 << ew) - 64'd1);
        w  = 64'd0;
        for (int e = 0; e < 64 / ew; e++) begin
            case (r[2*e +: 2])
                2'd0:    v = 64'd1 << (ew - 1);
                2'd1:    v = (64'd1 << (ew - 1)) - 64'd1;
                2'd2:    v = m;
                default: v = 64'd0;
            endcase
            v = v ^ {62'd0, r[32 + 2*e +: 2]};
            w = w | ((v & m) << (e * ew));
        end
        return w;
    endfunction

    // bit 64 tells whether a response is expected at all
    function automatic logic [64:0] ref_result(input logic [2:0] mnr, input logic [5:0] fid,
                                               input logic [1:0] sew, input logic [63:0] d0,
                                               input logic [63:0] d1, input logic [7:0] be,
                                               input logic mask);
        logic [63:0] r;
        logic [63:0] m;
        logic [63:0] sb;
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] y;
        int          ew;
        r  = 64'd0;
        ew = 8 << sew;
        m  = (ew == 64) ? {64{1'b1}} : ((64'd1 << ew) - 64'd1);
        sb = 64'd1 << (ew - 1);
        if (mnr != OPIVV && mnr != OPIVI && mnr != OPIVX) begin
            return 65'd0;
        end
        if (fid == 6'b010111) begin
            for (int i = 0; i < 8; i++) begin
                r[8*i +: 8] = (mask || be[i]) ? d0[8*i +: 8] : d1[8*i +: 8];   // vmv.v is all data0
            end
            return {1'b1, r};
        end
        case (fid)
            6'b001001: return {1'b1, d0 & d1};
            6'b001010: return {1'b1, d0 | d1};
            6'b001011: return {1'b1, d0 ^ d1};
            default:   ;
        endcase
        if (fid[5:3] != 3'b000 || fid[2:0] == 3'd1) begin
            return 65'd0;
        end
        for (int e = 0; e < 64 / ew; e++) begin
            a = (d1 >> (e * ew)) & m;
            b = (d0 >> (e * ew)) & m;
            // with the sign bit flipped, unsigned order is signed order
            case (fid[2:0])
                3'd0:    y = a + b;
                3'd2:    y = a - b;
                3'd3:    y = b - a;
                3'd4:    y = (a < b) ? a : b;
                3'd5:    y = ((a ^ sb) < (b ^ sb)) ? a : b;
                3'd6:    y = (a < b) ? b : a;
                default: y = ((a ^ sb) < (b ^ sb)) ? b : a;
            endcase
            r = r | ((y & m) << (e * ew));
        end
        return {1'b1, r};
    endfunction

    task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("ERR time=%0t %s got=%h exp=%h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic report_test(input string name);
        $display("test %s finished with %0d errors", name, errors - last_errors);
        last_errors = errors;
    endtask

    // one cycle with a request of the given kind or an idle cycle
    task automatic issue_slot(input int kind);
        logic [63:0] r0;
        logic [63:0] r1;
        logic [63:0] r2;
        logic [63:0] r3;
        logic [2:0]  mnr;
        logic [5:0]  fid;
        logic [1:0]  sew;
        logic [63:0] d0;
        logic [63:0] d1;
        logic        msk;
        logic        idle;
        logic        edges;
        logic [64:0] exp_r;
        exp_t        ent;
        next_rand(r0);
        next_rand(r1);
        next_rand(r2);
        next_rand(r3);
        mnr   = (r0[1:0] == 2'd0) ? OPIVV : (r0[1:0] == 2'd1) ? OPIVI : OPIVX;
        sew   = r0[3:2];
        msk   = r0[4];
        d0    = r1;
        d1    = r2;
        idle  = 1'b0;
        edges = 1'b0;
        fid   = 6'd0;
        case (kind)
            1: begin
                case (r0[21:20])
                    2'd0:    fid = 6'b001001;
                    2'd1:    fid = 6'b001010;
                    2'd2:    fid = 6'b001011;
                    default: begin
                        fid = F_MERGE;
                        msk = 1'b1;
                    end
                endcase
            end
            2: begin
                fid = F_MERGE;
                msk = 1'b0;
            end
            3: fid = {3'b000, (r0[22:21] == 2'd0) ? 3'd0 : (r0[22:21] == 2'd1) ? 3'd2 : 3'd3};
            4: begin
                fid   = {4'b0001, r0[21:20]};
                edges = 1'b1;
            end
            default: begin
                case (r0[26:24])
                    3'd0: idle = 1'b1;
                    3'd1: fid = r3[5:0];   // mostly codes that match nothing
                    3'd2: mnr = 3'd2;      // add code in a format that is not integer
                    3'd3: fid = F_MERGE;
                    3'd4: fid = {3'b000, r3[2:0]};
                    3'd5: fid = {4'b0010, r3[1:0]};
                    default: begin
                        fid   = {4'b0001, r3[1:0]};
                        edges = 1'b1;
                    end
                endcase
            end
        endcase
        if (edges) begin
            d0 = edge_word(sew, r1);
            d1 = edge_word(sew, r2);
        end
        @(posedge clk);
        if (idle) begin
            req_valid <= 1'b0;
        end else begin
            started = 1'b1;
            req_valid   <= 1'b1;
            req_op_mnr  <= mnr;
            req_func_id <= fid;
            req_sew     <= sew_e'(sew);
            req_data0   <= d0;
            req_data1   <= d1;
            req_addr    <= r3[63:32];
            req_be      <= r0[15:8];
            req_start   <= r0[16];
            req_end     <= r0[17];
            req_mask    <= msk;
            exp_r = ref_result(mnr, fid, sew, d0, d1, r0[15:8], msk);
            if (exp_r[64]) begin
                ent.stamp = 32'(cyc + 1);   // count of this edge is not applied yet
                ent.data  = exp_r[63:0];
                ent.addr  = r3[63:32];
                ent.be    = r0[15:8];
                ent.sew   = sew;
                ent.first = r0[16];
                ent.last  = r0[17];
                exp_q.push_back(ent);
            end
        end
    endtask

    task automatic run_test(input string name, input int kind, input int n);
        for (int i = 0; i < n; i++) begin
            issue_slot(kind);
        end
        @(posedge clk);
        req_valid <= 1'b0;
        repeat (RESP_LAT + 1) @(posedge clk);
        report_test(name);
    endtask

    always @(negedge clk) begin
        exp_t e;
        if (!started) begin
            check_val("resp_valid", 64'(resp_valid), 64'd0);
            check_val("resp_data", resp_data, 64'd0);
            check_val("resp_addr", 64'(resp_addr), 64'd0);
            check_val("resp_be", 64'(resp_be), 64'd0);
            check_val("resp_sew", 64'(resp_sew), 64'd0);
            check_val("resp_start", 64'(resp_start), 64'd0);
            check_val("resp_end", 64'(resp_end), 64'd0);
        end else if (resp_valid) begin
            if (exp_q.size() == 0) begin
                $display("response at time %0t arrived with no request outstanding", $time);
                errors++;
            end else begin
                e = exp_q.pop_front();
                check_val("latency", 64'(cyc - e.stamp), 64'(RESP_LAT));
                check_val("resp_data", resp_data, e.data);
                check_val("resp_addr", 64'(resp_addr), 64'(e.addr));
                check_val("resp_be", 64'(resp_be), 64'(e.be));
                check_val("resp_sew", 64'(resp_sew), 64'(e.sew));
                check_val("resp_start", 64'(resp_start), 64'(e.first));
                check_val("resp_end", 64'(resp_end), 64'(e.last));
            end
        end else begin
            check_val("resp_start", 64'(resp_start), 64'd0);
            check_val("resp_end", 64'(resp_end), 64'd0);
        end
    end

    initial begin
        rst         <= 1'b1;
        req_valid   <= 1'b0;
        req_op_mnr  <= 3'd0;
        req_func_id <= '0;
        req_sew     <= SEW8;
        req_data0   <= '0;
        req_data1   <= '0;
        req_addr    <= '0;
        req_be      <= '0;
        req_start   <= 1'b0;
        req_end     <= 1'b0;
        req_mask    <= 1'b0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        repeat (2) @(posedge clk);
        report_test("reset");
        run_test("bitwise_move", 1, N_BIT);
        run_test("merge", 2, N_MERGE);
        run_test("add_sub", 3, N_ADD);
        run_test("min_max", 4, N_MINMAX);
        run_test("mixed_pipeline", 5, N_MIX);
        if (exp_q.size() != 0) begin
            $display("%0d expected responses never arrived", exp_q.size());
        end
        $display("summary: %0d errors, %0d missing responses", errors, exp_q.size());
        if (errors == 0 && exp_q.size() == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin
        #((TOTAL + 50) * 10);
        $display("timeout: the run did not finish within its time limit");
        $display("Errors found");
        $finish;
    end

endmodule

//--- src.f
valu_pkg.sv
valu_decode.sv
valu_bitwise_unit.sv
valu_add_unit.sv
valu_collect.sv
valu_top.sv
valu_tb_sva.sv
valu_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= valu_tb
LOG       ?= run.log
FLIST     ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
SIM       = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run check clean

all: check

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	-./$(SIM) +verilator+error+limit+100 > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^No errors$$" $(LOG)

check: run
	@if grep -q "^No errors$$" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL: see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
